// ==== logic/rvga_types.sv ====
package rvga_types;

  // ==============================
  // Widths and sizes
  // ==============================
  localparam int word_w   = 32;
  localparam int reg_w    = 5;
  localparam int shamt_w  = 5;
  localparam int num_regs = 32;

  // Issue queue, sized to the issuer's credits.
  localparam int queue_depth = 4;
  localparam int queue_ptr_w = $clog2(queue_depth);

  // Sink credits after reset.
  localparam int result_credits = 2;
  localparam int credit_w       = $clog2(result_credits + 1);

  typedef logic [word_w-1:0]      rvga_word;
  typedef logic [reg_w-1:0]       rvga_reg;
  typedef logic [shamt_w-1:0]     rvga_shamt;
  typedef logic [queue_ptr_w-1:0] rvga_qptr;
  typedef logic [queue_ptr_w:0]   rvga_qcnt;  // One extra bit for full.
  typedef logic [credit_w-1:0]    rvga_credit;

  // ==============================
  // Operations, coded as funct3
  // ==============================
  typedef enum logic [2:0] {
    op_add  = 3'b000,
    op_sll  = 3'b001,
    op_slt  = 3'b010,
    op_sltu = 3'b011,
    op_xor  = 3'b100,
    op_srl  = 3'b101,
    op_or   = 3'b110,
    op_and  = 3'b111
  } rvga_artop;

  // ==============================
  // Pipeline payloads
  // ==============================
  typedef struct packed {
    rvga_reg   rs1;
    rvga_reg   rs2;
    rvga_reg   rd;
    rvga_word  imm;
    logic      imm_v;  // Operand b from imm.
    rvga_artop artop;
    logic      alt;    // Sub with op_add, arithmetic with op_srl.
  } rvga_issue_t;

  typedef struct packed {
    rvga_issue_t inst;
    rvga_word    rs1_data;
    rvga_word    rs2_data;
  } rvga_fetch_t;

  typedef struct packed {
    rvga_reg  rd;
    rvga_word result;
  } rvga_result_t;

endpackage : rvga_types

// ==== logic/issue_queue.sv ====
module issue_queue
  import rvga_types::*;
  ( input  logic        clk
  , input  logic        rst_n
  , input  logic        issue_valid
  , input  rvga_issue_t issue
  , output logic        issue_credit
  , input  logic        q_pop
  , output logic        q_valid
  , output rvga_issue_t q_item
  );

  rvga_issue_t mem [queue_depth];
  rvga_qptr    wr_ptr;
  rvga_qptr    rd_ptr;
  rvga_qcnt    count;

  function automatic rvga_qptr next_ptr(rvga_qptr p);
    return (p == rvga_qptr'(queue_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign q_valid = (count != '0);
  assign q_item  = mem[rd_ptr];  // Head of queue.

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      mem[wr_ptr] <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      issue_credit <= 1'b0;
    end else begin
      if (issue_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (q_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({issue_valid, q_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per freed slot.
      issue_credit <= q_pop;
    end
  end

endmodule : issue_queue

// ==== logic/rfetch_stage.sv ====
module rfetch_stage
  import rvga_types::*;
  ( input  logic        clk
  , input  logic        rst_n
  , input  logic        q_valid
  , input  rvga_issue_t q_item
  , output logic        q_pop
  , input  logic        advance
  , input  logic        wb_en
  , input  rvga_reg     wb_rd
  , input  rvga_word    wb_data
  , output logic        f_valid
  , output rvga_fetch_t f_item
  );

  rvga_word regs [num_regs];
  rvga_word rs1_data;
  rvga_word rs2_data;
  logic     wb_live;

  // ==============================
  // Register file
  // ==============================
  assign wb_live = wb_en && (wb_rd != '0);  // x0 never written.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_live) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Read with bypass of the write landing this cycle.
  function automatic rvga_word read_port(rvga_reg idx);
    if (wb_live && (wb_rd == idx)) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_port(q_item.rs1);
    rs2_data = read_port(q_item.rs2);
  end

  // ==============================
  // Fetch register
  // ==============================
  assign q_pop = q_valid && advance;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      f_valid <= 1'b0;
    end else if (advance) begin
      f_valid <= q_valid;  // Bubble when queue is empty.
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      f_item.inst     <= q_item;
      f_item.rs1_data <= rs1_data;
      f_item.rs2_data <= rs2_data;
    end
  end

endmodule : rfetch_stage

// ==== logic/rvga_alu.sv ====
module rvga_alu
  import rvga_types::*;
  ( input  rvga_artop op
  , input  logic      alt
  , input  rvga_word  a
  , input  rvga_word  b
  , output rvga_word  o
  );

  rvga_word sum;
  logic     lt_s;
  logic     lt_u;

  always_comb begin
    sum  = alt ? (a - b) : (a + b);
    lt_s = ($signed(a) < $signed(b));
    lt_u = (a < b);
  end

  always_comb begin
    case (op)
      op_add:  o = sum;
      op_slt:  o = rvga_word'(lt_s);
      op_sltu: o = rvga_word'(lt_u);
      op_xor:  o = a ^ b;
      op_or:   o = a | b;
      op_and:  o = a & b;
      // Shifts are handled by the shifter.
      default: o = '0;
    endcase
  end

endmodule : rvga_alu

// ==== logic/rvga_shifter.sv ====
module rvga_shifter
  import rvga_types::*;
  ( input  rvga_artop op
  , input  logic      alt
  , input  rvga_word  a
  , input  rvga_shamt shamt
  , output rvga_word  o
  );

  rvga_word shl;
  rvga_word shr;

  always_comb begin
    shl = a << shamt;
    if (alt) begin
      shr = rvga_word'($signed(a) >>> shamt);  // Sign fill.
    end else begin
      shr = a >> shamt;
    end
  end

  always_comb begin
    case (op)
      op_sll:  o = shl;
      op_srl:  o = shr;
      default: o = '0;
    endcase
  end

endmodule : rvga_shifter

// ==== logic/execute_stage.sv ====
module execute_stage
  import rvga_types::*;
  ( input  logic         clk
  , input  logic         rst_n
  , input  logic         f_valid
  , input  rvga_fetch_t  f_item
  , input  logic         result_credit
  , output logic         advance
  , output logic         wb_en
  , output rvga_reg      wb_rd
  , output rvga_word     wb_data
  , output logic         result_valid
  , output rvga_result_t result
  );

  rvga_word   op_a;
  rvga_word   op_b;
  rvga_word   alu_o;
  rvga_word   sh_o;
  rvga_word   exec_o;
  rvga_credit credit_cnt;
  logic       have_credit;
  logic       send;

  // ==============================
  // Operands and result select
  // ==============================
  always_comb begin
    op_a   = f_item.rs1_data;
    op_b   = f_item.inst.imm_v ? f_item.inst.imm : f_item.rs2_data;
    exec_o = ((f_item.inst.artop == op_sll) || (f_item.inst.artop == op_srl)) ? sh_o : alu_o;
  end

  rvga_alu i_rvga_alu
    ( .op  (f_item.inst.artop)
    , .alt (f_item.inst.alt)
    , .a   (op_a)
    , .b   (op_b)
    , .o   (alu_o)
    );

  rvga_shifter i_rvga_shifter
    ( .op    (f_item.inst.artop)
    , .alt   (f_item.inst.alt)
    , .a     (op_a)
    , .shamt (op_b[shamt_w-1:0])
    , .o     (sh_o)
    );

  // ==============================
  // Credits and result register
  // ==============================
  assign have_credit = (credit_cnt != '0);
  assign send        = f_valid && have_credit;
  assign advance     = !f_valid || have_credit;  // Hold while stuck.

  assign wb_en   = send;
  assign wb_rd   = f_item.inst.rd;
  assign wb_data = exec_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt   <= rvga_credit'(result_credits);
      result_valid <= 1'b0;
    end else begin
      case ({result_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      result_valid <= send;  // One pulse per result.
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      result.rd     <= f_item.inst.rd;
      result.result <= exec_o;
    end
  end

endmodule : execute_stage

// ==== logic/rvga_exec_core.sv ====
module rvga_exec_core
  import rvga_types::*;
  ( input  logic         clk
  , input  logic         rst_n
  , input  logic         issue_valid
  , input  rvga_issue_t  issue
  , output logic         issue_credit
  , output logic         result_valid
  , output rvga_result_t result
  , input  logic         result_credit
  );

  // Queue to fetch.
  logic        q_valid;
  logic        q_pop;
  rvga_issue_t q_item;

  // Fetch to execute.
  logic        f_valid;
  rvga_fetch_t f_item;

  // Execute back to fetch.
  logic        advance;
  logic        wb_en;
  rvga_reg     wb_rd;
  rvga_word    wb_data;

  issue_queue i_issue_queue
    ( .clk          (clk)
    , .rst_n        (rst_n)
    , .issue_valid  (issue_valid)
    , .issue        (issue)
    , .issue_credit (issue_credit)
    , .q_pop        (q_pop)
    , .q_valid      (q_valid)
    , .q_item       (q_item)
    );

  rfetch_stage i_rfetch_stage
    ( .clk     (clk)
    , .rst_n   (rst_n)
    , .q_valid (q_valid)
    , .q_item  (q_item)
    , .q_pop   (q_pop)
    , .advance (advance)
    , .wb_en   (wb_en)
    , .wb_rd   (wb_rd)
    , .wb_data (wb_data)
    , .f_valid (f_valid)
    , .f_item  (f_item)
    );

  execute_stage i_execute_stage
    ( .clk           (clk)
    , .rst_n         (rst_n)
    , .f_valid       (f_valid)
    , .f_item        (f_item)
    , .result_credit (result_credit)
    , .advance       (advance)
    , .wb_en         (wb_en)
    , .wb_rd         (wb_rd)
    , .wb_data       (wb_data)
    , .result_valid  (result_valid)
    , .result        (result)
    );

endmodule : rvga_exec_core

// ==== verification/rvga_exec_core_assert.sv ====
module rvga_exec_core_assert
  import rvga_types::*;
  ( input logic       clk
  , input logic       rst_n
  , input logic       issue_credit
  , input logic       result_valid
  , input rvga_qcnt   q_count
  , input rvga_credit credit_cnt
  );

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  queue_bound: assert property (@(posedge clk) disable iff (!rst_n) q_count <= queue_depth)
    else begin
      $error("Issue queue count above its depth.");
      fail_count++;
    end

  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
                                 credit_cnt <= result_credits)
    else begin
      $error("Result credit count above its limit.");
      fail_count++;
    end

  // No send while the sink is full.
  send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
                                      (credit_cnt == '0) |=> !result_valid)
    else begin
      $error("Result sent without a credit.");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !issue_credit)
    else begin
      $error("Issue credit pulsed during reset.");
      fail_count++;
    end

endmodule : rvga_exec_core_assert

bind rvga_exec_core rvga_exec_core_assert i_rvga_exec_core_assert
  ( .clk          (clk)
  , .rst_n        (rst_n)
  , .issue_credit (issue_credit)
  , .result_valid (result_valid)
  , .q_count      (i_issue_queue.count)
  , .credit_cnt   (i_execute_stage.credit_cnt)
  );

// ==== verification/tb_rvga_exec_core.sv ====
module tb_rvga_exec_core
  import rvga_types::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         issue_valid;
  rvga_issue_t  issue;
  logic         issue_credit;
  logic         result_valid;
  rvga_result_t result;
  logic         result_credit;

  rvga_word     model_regs [num_regs];
  rvga_result_t expq [$];
  rvga_reg      src_a [4] = '{5'd1, 5'd2, 5'd3, 5'd4};
  rvga_reg      src_b [4] = '{5'd2, 5'd4, 5'd4, 5'd1};
  int           credits;
  int           issued;
  int           returned;
  int           received;
  int           freed;
  int           errors;
  int           mark;
  bit           hold_sink;
  bit           random_sink;
  int           seed = 32'h106542c3;
  int           sink_seed = ~32'h106542c3;

  always #4 clk = ~clk;

  rvga_exec_core i_rvga_exec_core
    ( .clk           (clk)
    , .rst_n         (rst_n)
    , .issue_valid   (issue_valid)
    , .issue         (issue)
    , .issue_credit  (issue_credit)
    , .result_valid  (result_valid)
    , .result        (result)
    , .result_credit (result_credit)
    );

  // ==============================
  // Reference model
  // ==============================
  function automatic rvga_result_t ref_exec(rvga_issue_t x);
    rvga_word a;
    rvga_word b;
    rvga_word r;
    a = model_regs[x.rs1];
    b = x.imm_v ? x.imm : model_regs[x.rs2];  // Second operand select.
    case (x.artop)
      op_add:  r = x.alt ? a - b : a + b;
      op_sll:  r = a << b[4:0];
      op_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_sltu: r = (a < b) ? 32'd1 : 32'd0;
      op_xor:  r = a ^ b;
      op_srl:  r = x.alt ? rvga_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
      op_or:   r = a | b;
      default: r = a & b;
    endcase
    if (x.rd != 5'd0) begin
      model_regs[x.rd] = r;
    end
    return '{rd: x.rd, result: r};
  endfunction

  function automatic rvga_issue_t make_inst(rvga_artop op, logic alt_bit, rvga_reg rd_i,
                                            rvga_reg rs1_i, rvga_reg rs2_i, logic use_imm,
                                            rvga_word imm_i);
    return '{rs1: rs1_i, rs2: rs2_i, rd: rd_i, imm: imm_i, imm_v: use_imm, artop: op,
             alt: alt_bit};
  endfunction

  function automatic rvga_issue_t rand_inst();
    rvga_issue_t x;
    x.rs1   = rvga_reg'($random(seed) & 7);  // Few registers, many hazards.
    x.rs2   = rvga_reg'($random(seed) & 7);
    x.rd    = rvga_reg'($random(seed) & 7);
    x.imm   = rvga_word'($random(seed));
    x.imm_v = 1'($random(seed));
    x.artop = rvga_artop'(3'($random(seed)));
    x.alt   = 1'($random(seed));
    return x;
  endfunction

  // ==============================
  // Credits and comparison
  // ==============================
  always @(posedge clk) begin
    if (rst_n && issue_credit) begin
      credits++;
      returned++;
      if (credits > queue_depth) begin
        $display("Issue credit returned at %0t without a matching issue", $time);
        errors++;
      end
    end
  end

  always @(posedge clk) begin : compare
    rvga_result_t exp;
    if (rst_n && result_valid) begin
      received++;
      if (expq.size() == 0) begin
        $display("Result at %0t arrived with no instruction pending", $time);
        errors++;
      end else begin
        exp = expq.pop_front();
        if (result.rd != exp.rd) begin
          $display("Mismatch at %0t: rd is %0d, expected %0d", $time, result.rd, exp.rd);
          errors++;
        end
        if (result.result != exp.result) begin
          $display("Mismatch at %0t: result is %h, expected %h", $time, result.result,
                   exp.result);
          errors++;
        end
      end
    end
  end

  // Sink frees one slot per consumed result.
  always @(negedge clk) begin
    result_credit = 1'b0;
    if (rst_n && !hold_sink && (freed < received)) begin
      if (!random_sink || (($random(sink_seed) & 1) == 0)) begin
        result_credit = 1'b1;
        freed++;
      end
    end
  end

  // ==============================
  // Issue and wait tasks
  // ==============================
  task automatic fail_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic issue_one(input rvga_issue_t x);
    int waited;
    waited = 0;
    while (credits == 0) begin
      if (waited == 200) begin
        fail_timeout("an issue credit");
      end
      waited++;
      @(negedge clk);
    end
    issue_valid = 1'b1;
    issue       = x;
    credits--;
    issued++;
    expq.push_back(ref_exec(x));
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic drain(input string name);
    int waited;
    waited = 0;
    while (expq.size() != 0 || freed != received || credits != queue_depth) begin
      if (waited == 2000) begin
        fail_timeout({"the end of test ", name});
      end
      waited++;
      @(negedge clk);
    end
    if (returned != issued) begin
      $display("Issue credits returned (%0d) differ from instructions issued (%0d)",
               returned, issued);
      errors++;
    end
    $display("Test %s done, %0d results so far, %0d errors", name, received, errors);
  endtask

  initial begin
    rst_n         = 1'b0;
    issue_valid   = 1'b0;
    issue         = '0;
    result_credit = 1'b0;
    hold_sink     = 1'b0;
    random_sink   = 1'b0;
    credits       = queue_depth;
    issued        = 0;
    returned      = 0;
    received      = 0;
    freed         = 0;
    errors        = 0;
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Loads, then every operation on register pairs.
    issue_one(make_inst(op_add, 1'b0, 5'd1, 5'd0, 5'd0, 1'b1, 32'h0000_1234));
    issue_one(make_inst(op_add, 1'b0, 5'd2, 5'd0, 5'd0, 1'b1, 32'hffff_fffb));
    issue_one(make_inst(op_add, 1'b0, 5'd3, 5'd0, 5'd0, 1'b1, 32'h8000_0000));
    issue_one(make_inst(op_add, 1'b0, 5'd4, 5'd0, 5'd0, 1'b1, 32'd3));
    for (int p = 0; p < 4; p++) begin
      for (int k = 0; k < 16; k++) begin
        issue_one(make_inst(rvga_artop'(k / 2), k[0], rvga_reg'(10 + k), src_a[p], src_b[p],
                            1'b0, '0));
      end
    end
    drain("operations");

    issue_one(make_inst(op_add, 1'b0, 5'd5, 5'd1, 5'd0, 1'b1, 32'd7));
    for (int i = 0; i < 24; i++) begin
      issue_one(make_inst(rvga_artop'(i % 8), i[1], rvga_reg'(5 + (i % 3)),
                          rvga_reg'(5 + ((i + 2) % 3)), 5'd5, i[2],
                          rvga_word'(i * 32'h0123_4567)));
    end
    drain("dependent chains");

    issue_one(make_inst(op_add, 1'b0, 5'd0, 5'd0, 5'd0, 1'b1, 32'd123));
    issue_one(make_inst(op_or, 1'b0, 5'd8, 5'd0, 5'd1, 1'b0, '0));
    issue_one(make_inst(op_add, 1'b0, 5'd9, 5'd0, 5'd0, 1'b0, '0));
    drain("x0 writes");

    hold_sink = 1'b1;
    mark      = received;
    repeat (30) begin
      if (credits > 0) begin
        issue_one(rand_inst());
      end else begin
        @(negedge clk);
      end
    end
    if (received - mark != result_credits) begin
      $display("Back-pressure let %0d results out instead of %0d", received - mark,
               result_credits);
      errors++;
    end
    if (credits != 0) begin
      $display("Issue credits kept coming back while the sink was stalled");
      errors++;
    end
    hold_sink = 1'b0;
    drain("back-pressure");

    random_sink = 1'b1;
    for (int n = 0; n < 200; n++) begin
      if (($random(seed) & 3) == 0) begin
        @(negedge clk);
      end
      issue_one(rand_inst());
    end
    drain("random stream");

    errors += i_rvga_exec_core.i_rvga_exec_core_assert.fail_count;
    $display("Done: %0d issued, %0d results, %0d errors", issued, received, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_rvga_exec_core

// ==== all.f ====
logic/rvga_types.sv
logic/issue_queue.sv
logic/rfetch_stage.sv
logic/rvga_alu.sv
logic/rvga_shifter.sv
logic/execute_stage.sv
logic/rvga_exec_core.sv
verification/rvga_exec_core_assert.sv
verification/tb_rvga_exec_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_rvga_exec_core -Mdir obj_dir &&
./obj_dir/Vtb_rvga_exec_core | tee /dev/stderr | grep -q "^TEST PASS$" &&
exit 0 || exit 1
